/* logic/net_addr_pkg.sv */
`default_nettype none

package net_addr_pkg;

	// ------------------------------------------------
	// address types
	// ------------------------------------------------

	typedef logic [47:0] mac_addr_t;	// board MAC, network byte order
	typedef logic [31:0] ip_addr_t;	// IPv4, first octet in the msbs

	// ------------------------------------------------
	// address constants
	// ------------------------------------------------

	// link-local fallback is 169.254.x.y with x.y from the MAC
	localparam logic [15:0] APIPA_PREFIX = {8'd169, 8'd254};

	// an assigned IP of 0.0.0.0 or 255.255.255.255 means none was set
	localparam ip_addr_t IP_NONE     = 32'h0000_0000;
	localparam ip_addr_t IP_ALL_ONES = 32'hFFFF_FFFF;

	// MAC bit overwritten by the inverted DIP switch 1,
	// lets two boards with the same stored MAC share a segment
	localparam int MAC_SWITCH_BIT = 1;

endpackage

`default_nettype wire

/* logic/link_ctrl_pkg.sv */
`default_nettype none

package link_ctrl_pkg;

	// ------------------------------------------------
	// state encodings
	// ------------------------------------------------

	typedef enum logic [2:0] {
		INIT      = 3'd0,	// hold everything in reset
		PHY_WRITE = 3'd1,	// program the PHY registers
		PHY_POLL  = 3'd2,	// wait for link and duplex
		STABILISE = 3'd3,	// let the network settle before DHCP
		DHCP_WAIT = 3'd4,	// discover sent, wait for ACK / NAK / timeout
		RUN       = 3'd5,	// address valid, Tx released
		MONITOR   = 3'd6	// keep re-reading link status
	} seq_state_t;

	typedef enum logic [1:0] {
		RN_COUNT  = 2'd0,	// counting lease seconds
		RN_WAIT   = 2'd1,	// request sent, watching for NAK or timeout
		RN_PARKED = 2'd2	// rediscovery failed too, give up until unbound
	} renew_state_t;

	typedef enum logic [1:0] {
		RP_IDLE = 2'd0,
		RP_ARP  = 2'd1,
		RP_PING = 2'd2
	} reply_state_t;

	// ------------------------------------------------
	// PHY status word (reg 0x10)
	// ------------------------------------------------

	localparam int PHY_LINK_BIT   = 0;	// link up
	localparam int PHY_DUPLEX_BIT = 2;	// full duplex

	// ------------------------------------------------
	// retries, waits, timeouts
	// ------------------------------------------------

	localparam int MAX_DHCP_RETRIES   = 3;	// extra attempts after the first discover
	localparam int STABLE_SECONDS     = 1;	// settle time before every discover
	localparam int RENEW_WAIT_SECONDS = 2;	// window after a renew request

	localparam logic [31:0] DEFAULT_RENEW_SECONDS = 32'd2073600;	// 24 days

	localparam int REPLY_CNT_W = 17;
	localparam logic [REPLY_CNT_W-1:0] REPLY_TIMEOUT = 17'd100000;	// cycles

endpackage

`default_nettype wire

/* logic/second_strobe.sv */
`timescale 1ns/100ps
`default_nettype none

module second_strobe #(
	parameter logic [24:0] ticks_per_second = 25'd12500000
) (
	input  wire  PHY_RX_CLOCK,
	input  wire  rst_n_i,
	output logic second_tick_o
);

	logic [24:0] tick_cnt_q;	// cycles into the current second

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (!rst_n_i) begin
			tick_cnt_q    <= '0;
			second_tick_o <= 1'b0;
		end else begin
			if (tick_cnt_q == ticks_per_second - 25'd1) begin	// last cycle of the second
				tick_cnt_q    <= '0;
				second_tick_o <= 1'b1;	// one-cycle strobe
			end else begin
				tick_cnt_q    <= tick_cnt_q + 25'd1;
				second_tick_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/link_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module link_sequencer #(
	parameter net_addr_pkg::mac_addr_t board_mac   = 48'h02_00_00_00_00_10,
	parameter net_addr_pkg::ip_addr_t  assigned_ip = net_addr_pkg::IP_NONE
) (
	input  wire                          PHY_RX_CLOCK,
	input  wire                          rst_n_i,
	input  wire                          second_tick_i,
	input  wire                          phy_write_done_i,
	input  wire                          phy_read_done_i,
	input  wire [15:0]                   phy_reg_data_i,
	input  wire                          dhcp_ack_i,
	input  wire                          dhcp_nak_i,
	input  wire                          dhcp_time_out_i,
	input  wire net_addr_pkg::ip_addr_t  dhcp_yiaddr_i,
	input  wire                          dipsw_i,
	output logic                         phy_write_o,
	output logic                         phy_read_o,
	output logic                         dhcp_discover_o,
	output logic                         core_reset_o,
	output logic                         tx_reset_o,
	output logic                         ip_valid_o,
	output logic                         dhcp_bound_o,
	output net_addr_pkg::mac_addr_t      this_mac_o,
	output net_addr_pkg::ip_addr_t       this_ip_o
);

	link_ctrl_pkg::seq_state_t state_q;

	logic                   assigned_ip_valid;	// static IP usable, skip DHCP
	logic                   use_apipa_q;	// DHCP gave up, fall back to link-local
	logic                   dhcp_ok_q;	// address came from a DHCP ACK
	logic [2:0]             retries_q;	// DHCP attempts beyond the first
	logic [3:0]             sec_cnt_q;	// seconds spent in STABILISE
	net_addr_pkg::ip_addr_t yiaddr_q;	// last address offered by the server
	logic                   link_up;
	logic                   full_duplex;

	assign assigned_ip_valid = (assigned_ip != net_addr_pkg::IP_NONE) &&
	                           (assigned_ip != net_addr_pkg::IP_ALL_ONES);

	assign link_up     = phy_reg_data_i[link_ctrl_pkg::PHY_LINK_BIT];
	assign full_duplex = phy_reg_data_i[link_ctrl_pkg::PHY_DUPLEX_BIT];

	// ------------------------------------------------
	// start-up / link FSM
	// ------------------------------------------------

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (!rst_n_i) begin
			state_q         <= link_ctrl_pkg::INIT;
			phy_write_o     <= 1'b0;
			phy_read_o      <= 1'b0;
			dhcp_discover_o <= 1'b0;
			core_reset_o    <= 1'b1;
			tx_reset_o      <= 1'b1;
			ip_valid_o      <= 1'b0;
			use_apipa_q     <= 1'b0;
			dhcp_ok_q       <= 1'b0;
			retries_q       <= '0;
			sec_cnt_q       <= '0;
		end else begin
			dhcp_discover_o <= 1'b0;	// pulse, default low
			case (state_q)
				link_ctrl_pkg::INIT: begin	// also the restart point after link loss
					core_reset_o <= 1'b1;
					tx_reset_o   <= 1'b1;
					ip_valid_o   <= 1'b0;
					phy_read_o   <= 1'b0;
					use_apipa_q  <= 1'b0;
					dhcp_ok_q    <= 1'b0;
					retries_q    <= '0;
					sec_cnt_q    <= '0;
					state_q      <= link_ctrl_pkg::PHY_WRITE;
				end
				link_ctrl_pkg::PHY_WRITE: begin
					if (phy_write_done_i) begin	// drop the request the cycle after done
						phy_write_o <= 1'b0;
						state_q     <= link_ctrl_pkg::PHY_POLL;
					end else begin
						phy_write_o <= 1'b1;
					end
				end
				link_ctrl_pkg::PHY_POLL: begin
					phy_read_o <= ~phy_read_done_i;	// re-issue the read until happy
					if (phy_read_done_i && link_up) begin
						core_reset_o <= 1'b0;	// link is up, cores may run
						if (full_duplex) begin	// half duplex keeps polling
							sec_cnt_q <= '0;
							state_q   <= assigned_ip_valid ? link_ctrl_pkg::RUN
							                               : link_ctrl_pkg::STABILISE;
						end
					end
				end
				link_ctrl_pkg::STABILISE: begin
					if (second_tick_i) begin
						if (sec_cnt_q == 4'(link_ctrl_pkg::STABLE_SECONDS - 1)) begin
							sec_cnt_q       <= '0;
							dhcp_discover_o <= 1'b1;
							state_q         <= link_ctrl_pkg::DHCP_WAIT;
						end else begin
							sec_cnt_q <= sec_cnt_q + 4'd1;
						end
					end
				end
				link_ctrl_pkg::DHCP_WAIT: begin
					if (dhcp_ack_i) begin
						dhcp_ok_q <= 1'b1;
						state_q   <= link_ctrl_pkg::RUN;
					end else if (dhcp_nak_i || dhcp_time_out_i) begin
						if (retries_q == 3'(link_ctrl_pkg::MAX_DHCP_RETRIES)) begin
							use_apipa_q <= 1'b1;	// out of retries
							state_q     <= link_ctrl_pkg::RUN;
						end else begin
							retries_q <= retries_q + 3'd1;
							state_q   <= link_ctrl_pkg::STABILISE;	// wait, then try again
						end
					end
				end
				link_ctrl_pkg::RUN: begin
					ip_valid_o <= 1'b1;
					tx_reset_o <= 1'b0;	// UDP/IP Tx may send now
					phy_read_o <= 1'b1;	// start the next status read
					state_q    <= link_ctrl_pkg::MONITOR;
				end
				link_ctrl_pkg::MONITOR: begin
					phy_read_o <= ~phy_read_done_i;
					if (phy_read_done_i) begin
						state_q <= link_up ? link_ctrl_pkg::RUN	// still connected
						                   : link_ctrl_pkg::INIT;	// lost it, start over
					end
				end
				default: state_q <= link_ctrl_pkg::INIT;
			endcase
		end
	end

	// offered address, also refreshed by later renew / rediscover ACKs
	always_ff @(posedge PHY_RX_CLOCK) begin
		if (dhcp_ack_i && ((state_q == link_ctrl_pkg::DHCP_WAIT) || dhcp_bound_o))
			yiaddr_q <= dhcp_yiaddr_i;
	end

	assign dhcp_bound_o = dhcp_ok_q &&
	                      ((state_q == link_ctrl_pkg::RUN) || (state_q == link_ctrl_pkg::MONITOR));

	// ------------------------------------------------
	// address selection
	// ------------------------------------------------

	always_comb begin
		this_mac_o = board_mac;
		this_mac_o[net_addr_pkg::MAC_SWITCH_BIT] = ~dipsw_i;	// switch picks the board variant
	end

	assign this_ip_o = assigned_ip_valid ? assigned_ip :
	                   use_apipa_q       ? {net_addr_pkg::APIPA_PREFIX, this_mac_o[15:0]} :
	                                       yiaddr_q;

endmodule

`default_nettype wire

/* logic/lease_renewer.sv */
`timescale 1ns/100ps
`default_nettype none

module lease_renewer (
	input  wire        PHY_RX_CLOCK,
	input  wire        rst_n_i,
	input  wire        second_tick_i,
	input  wire        dhcp_bound_i,
	input  wire        dhcp_ack_i,
	input  wire        dhcp_nak_i,
	input  wire        dhcp_time_out_i,
	input  wire [31:0] dhcp_lease_i,
	output logic       dhcp_renew_o,
	output logic       dhcp_rediscover_o
);

	link_ctrl_pkg::renew_state_t state_q;

	logic [31:0] lease_q;	// lease in seconds from the last ACK
	logic [31:0] interval;	// seconds between renewals
	logic [31:0] sec_cnt_q;	// seconds counted toward the next renewal
	logic [2:0]  wait_cnt_q;	// seconds into the answer window
	logic        second_try_q;	// previous renewal failed
	logic        fail_q;	// NAK or timeout seen in the window
	logic        fail_now;

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (dhcp_ack_i)
			lease_q <= dhcp_lease_i;
	end

	// renew at half the lease, a zero lease means the server gave no limit
	assign interval = (lease_q == 32'd0) ? link_ctrl_pkg::DEFAULT_RENEW_SECONDS : (lease_q >> 1);
	assign fail_now = fail_q || dhcp_nak_i || dhcp_time_out_i;

	// ------------------------------------------------
	// renewal FSM
	// ------------------------------------------------

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (!rst_n_i) begin
			state_q           <= link_ctrl_pkg::RN_COUNT;
			sec_cnt_q         <= '0;
			wait_cnt_q        <= '0;
			second_try_q      <= 1'b0;
			fail_q            <= 1'b0;
			dhcp_renew_o      <= 1'b0;
			dhcp_rediscover_o <= 1'b0;
		end else begin
			dhcp_renew_o      <= 1'b0;	// pulses, default low
			dhcp_rediscover_o <= 1'b0;
			if (!dhcp_bound_i) begin	// no DHCP address, nothing to renew
				state_q      <= link_ctrl_pkg::RN_COUNT;
				sec_cnt_q    <= '0;
				wait_cnt_q   <= '0;
				second_try_q <= 1'b0;
				fail_q       <= 1'b0;
			end else begin
				case (state_q)
					link_ctrl_pkg::RN_COUNT: begin
						if (second_tick_i) begin
							if (sec_cnt_q + 32'd1 >= interval) begin	// lease half gone
								sec_cnt_q         <= '0;
								wait_cnt_q        <= '0;
								fail_q            <= 1'b0;
								dhcp_renew_o      <= ~second_try_q;
								dhcp_rediscover_o <= second_try_q;	// last ditch broadcast
								state_q           <= link_ctrl_pkg::RN_WAIT;
							end else begin
								sec_cnt_q <= sec_cnt_q + 32'd1;
							end
						end
					end
					link_ctrl_pkg::RN_WAIT: begin
						if (dhcp_nak_i || dhcp_time_out_i)
							fail_q <= 1'b1;
						if (second_tick_i) begin
							if (wait_cnt_q == 3'(link_ctrl_pkg::RENEW_WAIT_SECONDS - 1)) begin
								fail_q <= 1'b0;
								if (!fail_now) begin	// renewed, full interval again
									second_try_q <= 1'b0;
									sec_cnt_q    <= '0;
									state_q      <= link_ctrl_pkg::RN_COUNT;
								end else if (second_try_q) begin
									state_q <= link_ctrl_pkg::RN_PARKED;
								end else begin
									second_try_q <= 1'b1;
									sec_cnt_q    <= interval - (interval >> 2);	// retry at 3/4
									state_q      <= link_ctrl_pkg::RN_COUNT;
								end
							end else begin
								wait_cnt_q <= wait_cnt_q + 3'd1;
							end
						end
					end
					link_ctrl_pkg::RN_PARKED: state_q <= link_ctrl_pkg::RN_PARKED;	// until unbound
					default: state_q <= link_ctrl_pkg::RN_COUNT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* logic/reply_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module reply_arbiter (
	input  wire  PHY_RX_CLOCK,
	input  wire  rst_n_i,
	input  wire  arp_request_i,
	input  wire  ping_request_i,
	input  wire  arp_sent_i,
	input  wire  ping_sent_i,
	output logic send_arp_o,
	output logic ping_reply_o
);

	link_ctrl_pkg::reply_state_t state_q;

	logic [link_ctrl_pkg::REPLY_CNT_W-1:0] times_up_q;	// so a lost sent strobe cannot hang us
	logic                                  timed_out;

	assign timed_out = (times_up_q > link_ctrl_pkg::REPLY_TIMEOUT);

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (!rst_n_i) begin
			state_q    <= link_ctrl_pkg::RP_IDLE;
			times_up_q <= '0;
		end else begin
			case (state_q)
				link_ctrl_pkg::RP_IDLE: begin
					times_up_q <= '0;
					if (arp_request_i)	// ARP first when both arrive together
						state_q <= link_ctrl_pkg::RP_ARP;
					else if (ping_request_i)
						state_q <= link_ctrl_pkg::RP_PING;
				end
				link_ctrl_pkg::RP_ARP: begin
					times_up_q <= times_up_q + 1'b1;
					if (arp_sent_i || timed_out)
						state_q <= link_ctrl_pkg::RP_IDLE;
				end
				link_ctrl_pkg::RP_PING: begin
					times_up_q <= times_up_q + 1'b1;
					if (ping_sent_i || timed_out)
						state_q <= link_ctrl_pkg::RP_IDLE;
				end
				default: state_q <= link_ctrl_pkg::RP_IDLE;
			endcase
		end
	end

	// requests seen while busy are dropped
	assign send_arp_o   = (state_q == link_ctrl_pkg::RP_ARP);
	assign ping_reply_o = (state_q == link_ctrl_pkg::RP_PING);

endmodule

`default_nettype wire

/* logic/netif_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module netif_ctrl_top #(
	parameter net_addr_pkg::mac_addr_t board_mac        = 48'h02_00_00_00_00_10,
	parameter net_addr_pkg::ip_addr_t  assigned_ip      = net_addr_pkg::IP_NONE,
	parameter logic [24:0]             ticks_per_second = 25'd12500000
) (
	input  wire                          PHY_RX_CLOCK,
	input  wire                          rst_n_i,
	// PHY management engine
	output logic                         phy_write_o,
	input  wire                          phy_write_done_i,
	output logic                         phy_read_o,
	input  wire                          phy_read_done_i,
	input  wire [15:0]                   phy_reg_data_i,
	// DHCP engine
	output logic                         dhcp_discover_o,
	output logic                         dhcp_renew_o,
	output logic                         dhcp_rediscover_o,
	input  wire                          dhcp_ack_i,
	input  wire                          dhcp_nak_i,
	input  wire                          dhcp_time_out_i,
	input  wire net_addr_pkg::ip_addr_t  dhcp_yiaddr_i,
	input  wire [31:0]                   dhcp_lease_i,
	// status and addresses
	input  wire [1:0]                    dipsw_i,
	output logic                         core_reset_o,
	output logic                         tx_reset_o,
	output logic                         ip_valid_o,
	output net_addr_pkg::mac_addr_t      this_mac_o,
	output net_addr_pkg::ip_addr_t       this_ip_o,
	// ARP / ping replies from Rx MAC to Tx MAC
	input  wire                          arp_request_i,
	input  wire                          ping_request_i,
	input  wire                          arp_sent_i,
	input  wire                          ping_sent_i,
	output logic                         send_arp_o,
	output logic                         ping_reply_o
);

	logic second_tick;	// shared 1 s strobe
	logic dhcp_bound;	// running on a DHCP address

	second_strobe #(.ticks_per_second(ticks_per_second)) i_second_strobe (
		.PHY_RX_CLOCK (PHY_RX_CLOCK),
		.rst_n_i      (rst_n_i),
		.second_tick_o(second_tick)
	);

	link_sequencer #(.board_mac(board_mac), .assigned_ip(assigned_ip)) i_link_sequencer (
		.PHY_RX_CLOCK    (PHY_RX_CLOCK),
		.rst_n_i         (rst_n_i),
		.second_tick_i   (second_tick),
		.phy_write_done_i(phy_write_done_i),
		.phy_read_done_i (phy_read_done_i),
		.phy_reg_data_i  (phy_reg_data_i),
		.dhcp_ack_i      (dhcp_ack_i),
		.dhcp_nak_i      (dhcp_nak_i),
		.dhcp_time_out_i (dhcp_time_out_i),
		.dhcp_yiaddr_i   (dhcp_yiaddr_i),
		.dipsw_i         (dipsw_i[1]),	// bit 0 is the ID switch, not used here
		.phy_write_o     (phy_write_o),
		.phy_read_o      (phy_read_o),
		.dhcp_discover_o (dhcp_discover_o),
		.core_reset_o    (core_reset_o),
		.tx_reset_o      (tx_reset_o),
		.ip_valid_o      (ip_valid_o),
		.dhcp_bound_o    (dhcp_bound),
		.this_mac_o      (this_mac_o),
		.this_ip_o       (this_ip_o)
	);

	lease_renewer i_lease_renewer (
		.PHY_RX_CLOCK     (PHY_RX_CLOCK),
		.rst_n_i          (rst_n_i),
		.second_tick_i    (second_tick),
		.dhcp_bound_i     (dhcp_bound),
		.dhcp_ack_i       (dhcp_ack_i),
		.dhcp_nak_i       (dhcp_nak_i),
		.dhcp_time_out_i  (dhcp_time_out_i),
		.dhcp_lease_i     (dhcp_lease_i),
		.dhcp_renew_o     (dhcp_renew_o),
		.dhcp_rediscover_o(dhcp_rediscover_o)
	);

	reply_arbiter i_reply_arbiter (
		.PHY_RX_CLOCK  (PHY_RX_CLOCK),
		.rst_n_i       (rst_n_i),
		.arp_request_i (arp_request_i),
		.ping_request_i(ping_request_i),
		.arp_sent_i    (arp_sent_i),
		.ping_sent_i   (ping_sent_i),
		.send_arp_o    (send_arp_o),
		.ping_reply_o  (ping_reply_o)
	);

endmodule

`default_nettype wire

/* dv/netif_ctrl_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module netif_ctrl_chk (
	input wire PHY_RX_CLOCK,
	input wire rst_n_i,
	input wire discover_i,
	input wire renew_i,
	input wire rediscover_i,
	input wire send_arp_i,
	input wire ping_reply_i,
	input wire ip_valid_i,
	input wire tx_reset_i
);

	int unsigned err_cnt = 0;	// polled by the testbench

	// --------------------------------------------------
	// reply levels
	// --------------------------------------------------

	reply_one_hot: assert property (@(posedge PHY_RX_CLOCK) disable iff (!rst_n_i)
		!(send_arp_i && ping_reply_i))
	else begin
		$error("send_arp_o and ping_reply_o high together");
		err_cnt++;
	end

	// DHCP requests are single-cycle strobes
	dhcp_pulse_width: assert property (@(posedge PHY_RX_CLOCK) disable iff (!rst_n_i)
		(discover_i || renew_i || rediscover_i) |=> !(discover_i || renew_i || rediscover_i))
	else begin
		$error("DHCP request pulse longer than one cycle");
		err_cnt++;
	end

	// Tx leaves reset no later than the address is flagged valid
	ip_valid_vs_tx: assert property (@(posedge PHY_RX_CLOCK) disable iff (!rst_n_i)
		!(ip_valid_i && tx_reset_i))
	else begin
		$error("ip_valid_o high while tx_reset_o still high");
		err_cnt++;
	end

endmodule

bind netif_ctrl_top netif_ctrl_chk i_netif_ctrl_chk (
	.PHY_RX_CLOCK(PHY_RX_CLOCK),
	.rst_n_i     (rst_n_i),
	.discover_i  (dhcp_discover_o),
	.renew_i     (dhcp_renew_o),
	.rediscover_i(dhcp_rediscover_o),
	.send_arp_i  (send_arp_o),
	.ping_reply_i(ping_reply_o),
	.ip_valid_i  (ip_valid_o),
	.tx_reset_i  (tx_reset_o)
);

`default_nettype wire

/* dv/netif_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module netif_ctrl_tb;

	localparam int                      TPS         = 8;	// short second for simulation
	localparam int                      CYCLE_LIMIT = 400000;
	localparam net_addr_pkg::mac_addr_t BOARD_MAC   = 48'h02_1a_c4_5e_93_b6;
	localparam net_addr_pkg::ip_addr_t  STATIC_IP   = {8'd192, 8'd168, 8'd1, 8'd20};
	localparam logic [15:0] LINK_MASK   = 16'd1 << link_ctrl_pkg::PHY_LINK_BIT;
	localparam logic [15:0] DUPLEX_MASK = 16'd1 << link_ctrl_pkg::PHY_DUPLEX_BIT;

	// kinds of DHCP request seen, and of answer given
	localparam int PULSE_NONE = 0, PULSE_DISCOVER = 1, PULSE_RENEW = 2, PULSE_REDISCOVER = 3;
	localparam int ANS_ACK = 0, ANS_NAK = 1, ANS_TIMEOUT = 2;

	logic PHY_RX_CLOCK, rst_n_i;
	logic phy_write_o, phy_write_done_i, phy_read_o, phy_read_done_i;
	logic [15:0] phy_reg_data_i;
	logic dhcp_discover_o, dhcp_renew_o, dhcp_rediscover_o;
	logic dhcp_ack_i, dhcp_nak_i, dhcp_time_out_i;
	net_addr_pkg::ip_addr_t dhcp_yiaddr_i;
	logic [31:0] dhcp_lease_i;
	logic [1:0] dipsw_i;
	logic core_reset_o, tx_reset_o, ip_valid_o;
	net_addr_pkg::mac_addr_t this_mac_o;
	net_addr_pkg::ip_addr_t this_ip_o;
	logic arp_request_i, ping_request_i, arp_sent_i, ping_sent_i;
	logic send_arp_o, ping_reply_o;

	// second DUT with a static IP, shares every input with the first
	logic st_discover, st_ip_valid;
	net_addr_pkg::ip_addr_t st_this_ip;

	int unsigned cycle_cnt = 0;
	int unsigned disc_cnt = 0;	// discover pulses of the DHCP DUT
	int unsigned st_disc_cnt = 0;

	netif_ctrl_top #(.board_mac(BOARD_MAC), .assigned_ip(net_addr_pkg::IP_NONE),
		.ticks_per_second(25'(TPS))) i_netif_ctrl_top (.*);

	netif_ctrl_top #(.board_mac(BOARD_MAC), .assigned_ip(STATIC_IP),
		.ticks_per_second(25'(TPS))) i_netif_ctrl_top_static (
		.phy_write_o      (),
		.phy_read_o       (),
		.dhcp_discover_o  (st_discover),
		.dhcp_renew_o     (),
		.dhcp_rediscover_o(),
		.core_reset_o     (),
		.tx_reset_o       (),
		.ip_valid_o       (st_ip_valid),
		.this_mac_o       (),
		.this_ip_o        (st_this_ip),
		.send_arp_o       (),
		.ping_reply_o     (),
		.*
	);

	initial begin
		PHY_RX_CLOCK = 1'b0;
		forever #2 PHY_RX_CLOCK = ~PHY_RX_CLOCK;	// 4 ns period
	end

	// --------------------------------------------------
	// failure handling, watchdog
	// --------------------------------------------------

	task automatic stop_with_failure;
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	function automatic int unsigned checker_errors;
		return i_netif_ctrl_top.i_netif_ctrl_chk.err_cnt +
		       i_netif_ctrl_top_static.i_netif_ctrl_chk.err_cnt;
	endfunction

	always @(negedge PHY_RX_CLOCK) begin	// mid-cycle, outputs settled
		cycle_cnt++;
		if (dhcp_discover_o) disc_cnt++;
		if (st_discover) st_disc_cnt++;
		if (checker_errors() != 0) begin
			$display("ERROR at %0t ns: a bound assertion failed", $time);
			stop_with_failure;
		end
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("ERROR at %0t ns: run exceeded %0d cycles", $time, CYCLE_LIMIT);
			stop_with_failure;
		end
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			stop_with_failure;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else begin
			$display("ERROR at %0t ns: %s", $time, what);
			stop_with_failure;
		end
	endtask

	// --------------------------------------------------
	// stand-in PHY and DHCP engines
	// --------------------------------------------------

	task automatic next_cycle;
		@(posedge PHY_RX_CLOCK);
		#1;	// drive and sample just after the edge
	endtask

	task automatic clear_inputs;
		phy_write_done_i = 1'b0;
		phy_read_done_i  = 1'b0;
		phy_reg_data_i   = '0;
		dhcp_ack_i       = 1'b0;
		dhcp_nak_i       = 1'b0;
		dhcp_time_out_i  = 1'b0;
		dhcp_yiaddr_i    = '0;
		dhcp_lease_i     = '0;
		dipsw_i          = 2'b00;
		arp_request_i    = 1'b0;
		ping_request_i   = 1'b0;
		arp_sent_i       = 1'b0;
		ping_sent_i      = 1'b0;
	endtask

	task automatic apply_reset;
		rst_n_i = 1'b0;
		clear_inputs;
		repeat (8) next_cycle;
		rst_n_i = 1'b1;
	endtask

	task automatic answer_phy_write;
		int n;
		n = 0;
		while (!phy_write_o) begin
			next_cycle;
			n++;
			check_true(n < 16, "phy_write_o never rose");
		end
		phy_write_done_i = 1'b1;
		next_cycle;
		phy_write_done_i = 1'b0;
	endtask

	task automatic answer_phy_read(input logic [15:0] status);
		int n;
		n = 0;
		while (!phy_read_o) begin
			next_cycle;
			n++;
			check_true(n < 16, "phy_read_o never rose");
		end
		phy_read_done_i = 1'b1;
		phy_reg_data_i  = status;	// sampled with the done strobe
		next_cycle;
		phy_read_done_i = 1'b0;
		phy_reg_data_i  = '0;
	endtask

	task automatic bring_up_link;
		apply_reset;
		answer_phy_write;
		answer_phy_read(LINK_MASK | DUPLEX_MASK);
	endtask

	task automatic wait_dhcp_pulse(input int limit, output int kind, output int n);
		kind = PULSE_NONE;
		n = 0;
		while (kind == PULSE_NONE) begin
			next_cycle;
			n++;
			if (dhcp_discover_o)
				kind = PULSE_DISCOVER;
			else if (dhcp_renew_o)
				kind = PULSE_RENEW;
			else if (dhcp_rediscover_o)
				kind = PULSE_REDISCOVER;
			else
				check_true(n < limit, "no DHCP request within the expected time");
		end
	endtask

	task automatic answer_dhcp(input int kind, input net_addr_pkg::ip_addr_t yiaddr,
		input logic [31:0] lease);
		dhcp_ack_i      = (kind == ANS_ACK);
		dhcp_nak_i      = (kind == ANS_NAK);
		dhcp_time_out_i = (kind == ANS_TIMEOUT);
		dhcp_yiaddr_i   = yiaddr;
		dhcp_lease_i    = lease;
		next_cycle;
		dhcp_ack_i      = 1'b0;
		dhcp_nak_i      = 1'b0;
		dhcp_time_out_i = 1'b0;
	endtask

	// board MAC with the switch bit inverted into place
	function automatic net_addr_pkg::mac_addr_t expected_mac(input logic sw);
		net_addr_pkg::mac_addr_t mac;
		mac = BOARD_MAC;
		mac[net_addr_pkg::MAC_SWITCH_BIT] = ~sw;
		return mac;
	endfunction

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic test_reset_and_link;
		apply_reset;	// still the reset values here
		check_val("core_reset_o", core_reset_o, 1'b1);
		check_val("tx_reset_o", tx_reset_o, 1'b1);
		check_val("ip_valid_o", ip_valid_o, 1'b0);
		check_val("phy_read_o", phy_read_o, 1'b0);
		check_val("dhcp pulses", {dhcp_discover_o, dhcp_renew_o, dhcp_rediscover_o}, 3'b000);
		check_val("reply levels", {send_arp_o, ping_reply_o}, 2'b00);
		next_cycle;
		check_val("phy_write_o", phy_write_o, 1'b0);
		next_cycle;
		check_val("phy_write_o", phy_write_o, 1'b1);	// second cycle after reset
		answer_phy_write;
		check_val("phy_write_o", phy_write_o, 1'b0);
		answer_phy_read(DUPLEX_MASK);	// no link yet, keep polling
		check_val("core_reset_o", core_reset_o, 1'b1);
		answer_phy_read(LINK_MASK | DUPLEX_MASK);
		check_val("core_reset_o", core_reset_o, 1'b0);
	endtask

	task automatic test_dhcp_success;
		int kind, n;
		net_addr_pkg::ip_addr_t ip;
		ip = $urandom;
		wait_dhcp_pulse(TPS * link_ctrl_pkg::STABLE_SECONDS + 1, kind, n);
		check_val("dhcp request kind", kind, PULSE_DISCOVER);
		answer_dhcp(ANS_ACK, ip, 32'd1000 + ($urandom % 32'd1000));	// long lease
		next_cycle;
		check_val("ip_valid_o", ip_valid_o, 1'b1);
		check_val("tx_reset_o", tx_reset_o, 1'b0);
		check_val("this_ip_o", this_ip_o, ip);
		check_val("this_mac_o", this_mac_o, expected_mac(1'b0));
		dipsw_i = 2'b10;
		next_cycle;
		check_val("this_mac_o", this_mac_o, expected_mac(1'b1));
	endtask

	task automatic test_retry_and_apipa;
		int kind, n;
		int unsigned base;
		net_addr_pkg::mac_addr_t mac;
		bring_up_link;
		base = disc_cnt;
		for (int i = 0; i <= link_ctrl_pkg::MAX_DHCP_RETRIES; i++) begin
			wait_dhcp_pulse(TPS * link_ctrl_pkg::STABLE_SECONDS + 1, kind, n);
			check_val("dhcp request kind", kind, PULSE_DISCOVER);
			answer_dhcp((i % 2 == 0) ? ANS_NAK : ANS_TIMEOUT, '0, '0);	// mix both failures
		end
		next_cycle;
		mac = expected_mac(dipsw_i[1]);
		check_val("ip_valid_o", ip_valid_o, 1'b1);
		check_val("this_ip_o", this_ip_o, {net_addr_pkg::APIPA_PREFIX, mac[15:0]});
		repeat (2 * TPS) next_cycle;	// no fifth attempt
		check_val("discover count", disc_cnt - base, link_ctrl_pkg::MAX_DHCP_RETRIES + 1);
		check_val("static ip_valid_o", st_ip_valid, 1'b1);
		check_val("static this_ip_o", st_this_ip, STATIC_IP);
		check_val("static discover count", st_disc_cnt, 0);
	endtask

	task automatic test_lease_renewal;
		int kind, n, interval, limit;
		bring_up_link;
		interval = 4 / 2;	// half of a 4 s lease
		limit    = (link_ctrl_pkg::RENEW_WAIT_SECONDS + interval + 1) * TPS;
		wait_dhcp_pulse(TPS * link_ctrl_pkg::STABLE_SECONDS + 1, kind, n);
		answer_dhcp(ANS_ACK, $urandom, 32'd4);
		wait_dhcp_pulse(interval * TPS + 1, kind, n);
		check_val("dhcp request kind", kind, PULSE_RENEW);
		check_true(n > (interval - 1) * TPS, "renew came before half the lease");
		next_cycle;
		answer_dhcp(ANS_NAK, '0, '0);	// inside the answer window
		wait_dhcp_pulse(limit, kind, n);
		check_val("dhcp request kind", kind, PULSE_REDISCOVER);
		answer_dhcp(ANS_ACK, $urandom, 32'd4);
		wait_dhcp_pulse(limit, kind, n);	// back to plain renewals
		check_val("dhcp request kind", kind, PULSE_RENEW);
	endtask

	task automatic test_replies;
		int n;
		arp_request_i = 1'b1;
		next_cycle;
		arp_request_i = 1'b0;
		check_val("send_arp_o", send_arp_o, 1'b1);
		repeat (3) next_cycle;
		check_val("send_arp_o", send_arp_o, 1'b1);	// held until sent
		arp_sent_i = 1'b1;
		next_cycle;
		arp_sent_i = 1'b0;
		check_val("send_arp_o", send_arp_o, 1'b0);
		arp_request_i  = 1'b1;
		ping_request_i = 1'b1;
		next_cycle;
		arp_request_i  = 1'b0;
		ping_request_i = 1'b0;
		check_val("send_arp_o", send_arp_o, 1'b1);	// ARP wins the tie
		check_val("ping_reply_o", ping_reply_o, 1'b0);
		arp_sent_i = 1'b1;
		next_cycle;
		arp_sent_i = 1'b0;
		ping_request_i = 1'b1;
		next_cycle;
		ping_request_i = 1'b0;
		check_val("ping_reply_o", ping_reply_o, 1'b1);
		n = 0;
		while (ping_reply_o) begin	// no sent strobe, wait for the timeout
			next_cycle;
			n++;
			check_true(n < link_ctrl_pkg::REPLY_TIMEOUT + 16, "ping_reply_o never timed out");
		end
		check_true(n > link_ctrl_pkg::REPLY_TIMEOUT, "ping_reply_o dropped before the timeout");
	endtask

	task automatic test_link_loss;
		answer_phy_read(DUPLEX_MASK);	// link bit clear while in MONITOR
		next_cycle;
		check_val("core_reset_o", core_reset_o, 1'b1);
		check_val("tx_reset_o", tx_reset_o, 1'b1);
		check_val("ip_valid_o", ip_valid_o, 1'b0);
		next_cycle;
		check_val("phy_write_o", phy_write_o, 1'b1);	// sequence starts over
	endtask

	initial begin
		rst_n_i = 1'b0;
		clear_inputs;
		void'($urandom(32'ha0ec2824));
		$display("test 1: reset and link-up");
		test_reset_and_link;
		$display("test 2: DHCP success");
		test_dhcp_success;
		$display("test 3: retries, APIPA and static IP");
		test_retry_and_apipa;
		$display("test 4: lease renewal");
		test_lease_renewal;
		$display("test 5: ARP and ping replies");
		test_replies;
		$display("test 6: link loss");
		test_link_loss;
		if (checker_errors() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_with_failure;
		end
	end

endmodule

`default_nettype wire

/* all.f */
logic/net_addr_pkg.sv
logic/link_ctrl_pkg.sv
logic/second_strobe.sv
logic/link_sequencer.sv
logic/lease_renewer.sv
logic/reply_arbiter.sv
logic/netif_ctrl_top.sv
dv/netif_ctrl_chk.sv
dv/netif_ctrl_tb.sv
